/* source/cpuPkg.sv */
/* Core package
   Widths, opcode and operand encodings, and the bundles passed between blocks */
package cpuPkg;

    localparam int dataWidth  = 8;
    localparam int instrWidth = 16;

    typedef logic [dataWidth-1:0] byteT;

    typedef enum logic [3:0] {
        opBra = 4'd0,
        opLd  = 4'd1,
        opSt  = 4'd2,
        opMov = 4'd3,
        opAnd = 4'd4,
        opOr  = 4'd5,
        opBne = 4'd15
    } opcodeT;

    typedef enum logic [3:0] {
        codePc    = 4'd0,
        codePcAlt = 4'd1,  // Second PC alias
        codeAr    = 4'd2,
        codeSp    = 4'd3,  // No register behind it
        codeR1    = 4'd4,
        codeR2    = 4'd5,
        codeR3    = 4'd6,
        codeR4    = 4'd7
    } operandT;

    // Low byte (src1 and src2) doubles as immediate or address
    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] dest;   // Bit 2 set means immediate addressing
        logic [3:0] src1;
        logic [3:0] src2;
    } instrT;

    typedef enum logic [1:0] {aluPassA, aluPassB, aluAnd, aluOr} aluOpT;

    typedef enum logic [1:0] {stepFetchLow, stepFetchHigh, stepExecute, stepFinish} stepT;

    typedef enum logic [1:0] {wbImmediate, wbMemory, wbAlu} wbSourceT;

    typedef struct packed {
        logic zero;
        logic negative;
    } flagsT;

    typedef struct packed {
        operandT  dest;
        operandT  srcA;
        operandT  srcB;
        aluOpT    aluOp;
        wbSourceT wbSource;
        logic     regWrite;
        logic     flagsLoad;
        logic     pcInc;
        logic     addrFromAr;  // Memory address from AR instead of PC
        logic     memRead;
        logic     memWrite;
    } ctrlT;

    typedef struct packed {
        byteT addr;
        byteT wrData;
        logic read;
        logic write;
    } memReqT;

endpackage

/* source/registerFile.sv */
/* General register file
   R1 to R4, one write port and two combinational read ports */
module registerFile (
    input  logic            clock,
    input  logic            rstN,
    input  logic            writeEn,
    input  cpuPkg::operandT writeSel,
    input  cpuPkg::byteT    writeData,
    input  cpuPkg::operandT readSelA,
    input  cpuPkg::operandT readSelB,
    output cpuPkg::byteT    readA,
    output cpuPkg::byteT    readB
);

    cpuPkg::byteT gpr [4];

    // Only codes 4 to 7 map onto a register
    function automatic logic isGeneral(input cpuPkg::operandT sel);
        return sel inside {cpuPkg::codeR1, cpuPkg::codeR2, cpuPkg::codeR3, cpuPkg::codeR4};
    endfunction

    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 0; i < 4; i++) begin
                gpr[i] <= '0;
            end
        end else if (writeEn && isGeneral(writeSel)) begin
            gpr[writeSel[1:0]] <= writeData;
        end
    end

    assign readA = isGeneral(readSelA) ? gpr[readSelA[1:0]] : '0;
    assign readB = isGeneral(readSelB) ? gpr[readSelB[1:0]] : '0;

endmodule

/* source/addressRegisters.sv */
/* Address registers
   Program counter, address register and the memory address select */
module addressRegisters (
    input  logic         clock,
    input  logic         rstN,
    input  logic         pcInc,
    input  logic         pcLoad,
    input  logic         arLoad,
    input  cpuPkg::byteT loadData,
    input  logic         addrFromAr,
    output cpuPkg::byteT pc,
    output cpuPkg::byteT ar,
    output cpuPkg::byteT memAddr
);

    always_ff @(posedge clock) begin
        if (!rstN) begin
            pc <= '0;
            ar <= '0;
        end else begin
            if (pcLoad) begin
                pc <= loadData;  // Branch or MOV into PC
            end else if (pcInc) begin
                pc <= pc + 1'b1;
            end

            if (arLoad) begin
                ar <= loadData;
            end
        end
    end

    // Fetches use PC, direct LD and ST use AR
    assign memAddr = addrFromAr ? ar : pc;

endmodule

/* source/alu.sv */
/* ALU
   Pass, AND and OR with registered zero and negative flags */
module alu (
    input  logic          clock,
    input  logic          rstN,
    input  cpuPkg::aluOpT op,
    input  cpuPkg::byteT  a,
    input  cpuPkg::byteT  b,
    input  logic          flagsLoad,
    output cpuPkg::byteT  result,
    output cpuPkg::flagsT flags
);

    always_comb begin
        case (op)
            cpuPkg::aluPassA: begin
                result = a;
            end
            cpuPkg::aluPassB: begin
                result = b;
            end
            cpuPkg::aluAnd: begin
                result = a & b;
            end
            default: begin
                result = a | b;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            flags <= '0;
        end else if (flagsLoad) begin
            flags.zero     <= (result == '0);
            flags.negative <= result[cpuPkg::dataWidth-1];  // Sign bit
        end
    end

endmodule

/* source/dataPath.sv */
/* Data path
   Operand and write-back muxes around the registers and ALU, builds the memory request */
module dataPath (
    input  logic           clock,
    input  logic           rstN,
    input  cpuPkg::ctrlT   ctrl,
    input  cpuPkg::instrT  instr,
    input  cpuPkg::byteT   memRdData,
    output cpuPkg::flagsT  flags,
    output cpuPkg::memReqT memReq
);

    cpuPkg::byteT pc;
    cpuPkg::byteT ar;
    cpuPkg::byteT regA;
    cpuPkg::byteT regB;
    cpuPkg::byteT operandA;
    cpuPkg::byteT aluResult;
    cpuPkg::byteT wbData;
    cpuPkg::byteT memAddr;
    logic         pcLoad;
    logic         arLoad;

    // Operand A may be any code, PC and AR come from here
    always_comb begin
        case (ctrl.srcA)
            cpuPkg::codePc, cpuPkg::codePcAlt: begin
                operandA = pc;
            end
            cpuPkg::codeAr: begin
                operandA = ar;
            end
            default: begin
                operandA = regA;
            end
        endcase
    end

    always_comb begin
        case (ctrl.wbSource)
            cpuPkg::wbImmediate: begin
                wbData = {instr.src1, instr.src2};
            end
            cpuPkg::wbMemory: begin
                wbData = memRdData;
            end
            default: begin
                wbData = aluResult;
            end
        endcase
    end

    assign pcLoad = ctrl.regWrite &&
                    (ctrl.dest == cpuPkg::codePc || ctrl.dest == cpuPkg::codePcAlt);
    assign arLoad = ctrl.regWrite && (ctrl.dest == cpuPkg::codeAr);

    registerFile u_registerFile (
        .clock     (clock),
        .rstN      (rstN),
        .writeEn   (ctrl.regWrite),  // Non-general codes dropped inside
        .writeSel  (ctrl.dest),
        .writeData (wbData),
        .readSelA  (ctrl.srcA),
        .readSelB  (ctrl.srcB),
        .readA     (regA),
        .readB     (regB)
    );

    addressRegisters u_addressRegisters (
        .clock      (clock),
        .rstN       (rstN),
        .pcInc      (ctrl.pcInc),
        .pcLoad     (pcLoad),
        .arLoad     (arLoad),
        .loadData   (wbData),
        .addrFromAr (ctrl.addrFromAr),
        .pc         (pc),
        .ar         (ar),
        .memAddr    (memAddr)
    );

    alu u_alu (
        .clock     (clock),
        .rstN      (rstN),
        .op        (ctrl.aluOp),
        .a         (operandA),
        .b         (regB),
        .flagsLoad (ctrl.flagsLoad),
        .result    (aluResult),
        .flags     (flags)
    );

    assign memReq.addr   = memAddr;
    assign memReq.wrData = aluResult;  // ST passes its register through operand B
    assign memReq.read   = ctrl.memRead;
    assign memReq.write  = ctrl.memWrite;

endmodule

/* source/controlSequencer.sv */
/* Control sequencer
   Instruction register, fetch and execute steps, decode into the control word */
module controlSequencer (
    input  logic          clock,
    input  logic          rstN,
    input  cpuPkg::byteT  memRdData,
    input  cpuPkg::flagsT flags,
    output cpuPkg::ctrlT  ctrl,
    output cpuPkg::instrT instr
);

    logic [cpuPkg::instrWidth-1:0] irBits;
    cpuPkg::stepT                  step;
    cpuPkg::stepT                  stepNext;
    cpuPkg::opcodeT                opcode;
    cpuPkg::operandT               ldstReg;
    cpuPkg::aluOpT                 logicOp;
    logic                          ldDirect;
    logic                          needsFinish;

    assign instr       = cpuPkg::instrT'(irBits);
    assign opcode      = cpuPkg::opcodeT'(instr.opcode);
    assign ldstReg     = cpuPkg::operandT'({2'b01, instr.dest[1:0]});  // R1 to R4
    assign ldDirect    = (opcode == cpuPkg::opLd) && !instr.dest[2];
    assign needsFinish = ldDirect || (opcode == cpuPkg::opSt);

    // Low byte first, little-endian in memory
    always_ff @(posedge clock) begin
        if (step == cpuPkg::stepFetchLow) begin
            irBits[cpuPkg::dataWidth-1:0] <= memRdData;
        end
        if (step == cpuPkg::stepFetchHigh) begin
            irBits[cpuPkg::instrWidth-1:cpuPkg::dataWidth] <= memRdData;
        end
    end

    always_comb begin
        case (step)
            cpuPkg::stepFetchLow: begin
                stepNext = cpuPkg::stepFetchHigh;
            end
            cpuPkg::stepFetchHigh: begin
                stepNext = cpuPkg::stepExecute;
            end
            cpuPkg::stepExecute: begin
                stepNext = needsFinish ? cpuPkg::stepFinish : cpuPkg::stepFetchLow;
            end
            default: begin
                stepNext = cpuPkg::stepFetchLow;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            step <= cpuPkg::stepFetchLow;
        end else begin
            step <= stepNext;
        end
    end

    always_comb begin
        case (opcode)
            cpuPkg::opAnd: begin
                logicOp = cpuPkg::aluAnd;
            end
            cpuPkg::opOr: begin
                logicOp = cpuPkg::aluOr;
            end
            default: begin
                logicOp = cpuPkg::aluPassA;  // MOV
            end
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (step)
            cpuPkg::stepFetchLow, cpuPkg::stepFetchHigh: begin
                ctrl.memRead = 1'b1;
                ctrl.pcInc   = 1'b1;
            end
            cpuPkg::stepExecute: begin
                case (opcode)
                    cpuPkg::opBra, cpuPkg::opBne: begin
                        ctrl.dest     = cpuPkg::codePc;
                        ctrl.wbSource = cpuPkg::wbImmediate;
                        ctrl.regWrite = (opcode == cpuPkg::opBra) || !flags.zero;
                    end
                    cpuPkg::opLd, cpuPkg::opSt: begin
                        // Direct forms stage the address in AR first
                        ctrl.dest     = (opcode == cpuPkg::opSt || ldDirect) ?
                                        cpuPkg::codeAr : ldstReg;
                        ctrl.wbSource = cpuPkg::wbImmediate;
                        ctrl.regWrite = 1'b1;
                    end
                    cpuPkg::opMov, cpuPkg::opAnd, cpuPkg::opOr: begin
                        ctrl.dest      = cpuPkg::operandT'(instr.dest);
                        ctrl.srcA      = cpuPkg::operandT'(instr.src1);
                        ctrl.srcB      = cpuPkg::operandT'(instr.src2);
                        ctrl.aluOp     = logicOp;
                        ctrl.wbSource  = cpuPkg::wbAlu;
                        ctrl.regWrite  = 1'b1;
                        ctrl.flagsLoad = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            default: begin
                ctrl.addrFromAr = 1'b1;
                ctrl.srcB       = ldstReg;
                ctrl.aluOp      = cpuPkg::aluPassB;
                if (opcode == cpuPkg::opLd) begin
                    ctrl.memRead  = 1'b1;
                    ctrl.dest     = ldstReg;
                    ctrl.wbSource = cpuPkg::wbMemory;
                    ctrl.regWrite = 1'b1;
                end else begin
                    ctrl.memWrite = 1'b1;  // ST strobe
                end
            end
        endcase
    end

endmodule

/* source/cpuCore.sv */
/* CPU core top
   Sequencer and data path joined, memory bus exposed */
module cpuCore (
    input  logic           clock,
    input  logic           rstN,
    output cpuPkg::memReqT memReq,
    input  cpuPkg::byteT   memRdData
);

    cpuPkg::ctrlT  ctrl;
    cpuPkg::instrT instr;
    cpuPkg::flagsT flags;

    controlSequencer u_controlSequencer (
        .clock     (clock),
        .rstN      (rstN),
        .memRdData (memRdData),  // Instruction bytes
        .flags     (flags),
        .ctrl      (ctrl),
        .instr     (instr)
    );

    dataPath u_dataPath (
        .clock     (clock),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .instr     (instr),
        .memRdData (memRdData),
        .flags     (flags),
        .memReq    (memReq)
    );

endmodule

/* verif/tbClock.sv */
/* Testbench clock and reset
   Clock with a period of 100, reset held low over the first 16 rising edges */
module tbClock (
    output logic clock,
    output logic rstN
);

    localparam int halfPeriod  = 50;
    localparam int resetCycles = 16;
    localparam int driveDelay  = 5;

    initial begin
        clock = 1'b0;
        forever #halfPeriod clock = ~clock;
    end

    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clock);
        #driveDelay rstN = 1'b1;  // Released just after the edge
    end

endmodule

/* verif/cpuCore_props.sv */
/* Bus and step assertions for the CPU core
   Strobe exclusion, stores only in the finish step, fetch addresses in sequence */
module cpuCoreProps (
    input logic           clock,
    input logic           rstN,
    input cpuPkg::memReqT memReq,
    input cpuPkg::stepT   step
);

    readWriteExclusive: assert property (
        @(posedge clock) disable iff (!rstN)
        !(memReq.read && memReq.write)
    ) else $error("memory read and write strobes high together");

    writeInFinish: assert property (
        @(posedge clock) disable iff (!rstN)
        memReq.write |-> step == cpuPkg::stepFinish
    ) else $error("memory write outside the finish step");

    // High byte fetch follows the low byte address
    fetchInSequence: assert property (
        @(posedge clock) disable iff (!rstN)
        (step == cpuPkg::stepFetchLow && memReq.read) |=>
            (memReq.read && memReq.addr == cpuPkg::byteT'($past(memReq.addr) + 1'b1))
    ) else $error("fetch addresses are not consecutive");

endmodule

bind cpuCore cpuCoreProps u_cpuCoreProps (
    .clock  (clock),
    .rstN   (rstN),
    .memReq (memReq),
    .step   (u_controlSequencer.step)
);

/* verif/cpuCoreTb.sv */
/* CPU core testbench
   Memory model loaded from the case file, checks the first fetches and every store */
module cpuCoreTb;

    localparam int writeTimeout = 200;
    localparam int quietCycles  = 100;
    localparam int resetTimeout = 40;
    localparam int caseWords    = 64;

    logic           clock;
    logic           rstN;
    cpuPkg::memReqT memReq;
    cpuPkg::byteT   memRdData;
    cpuPkg::byteT   mem [256];
    logic [27:0]    caseTable [caseWords];  // Kind, address, value
    cpuPkg::byteT   expAddr [$];
    cpuPkg::byteT   expData [$];

    tbClock u_tbClock (
        .clock (clock),
        .rstN  (rstN)
    );

    cpuCore u_cpuCore (
        .clock     (clock),
        .rstN      (rstN),
        .memReq    (memReq),
        .memRdData (memRdData)
    );

    assign memRdData = memReq.read ? mem[memReq.addr] : '0;  // Combinational read

    always @(posedge clock) begin
        if (rstN && memReq.write) begin
            mem[memReq.addr] = memReq.wrData;
        end
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic checkByte(input string name, input cpuPkg::byteT actual,
                             input cpuPkg::byteT expected);
        if (actual !== expected) begin
            failRun($sformatf("error at %0t: %s is %h, expected %h",
                              $time, name, actual, expected));
        end
    endtask

    // Write data is a don't care on a fetch
    task automatic checkRequest(input string name, input cpuPkg::memReqT actual,
                                input cpuPkg::memReqT expected);
        checkByte({name, ".addr"}, actual.addr, expected.addr);
        if (actual.read !== expected.read || actual.write !== expected.write) begin
            failRun($sformatf("error at %0t: %s read,write is %b,%b, expected %b,%b",
                              $time, name, actual.read, actual.write,
                              expected.read, expected.write));
        end
    endtask

    task automatic loadCases();
        logic [3:0]   kind;
        cpuPkg::byteT addr;
        logic [15:0]  value;
        for (int i = 0; i < 256; i++) begin
            mem[i] = cpuPkg::byteT'(i) ^ 8'ha5;
        end
        for (int i = 0; i < caseWords; i++) begin
            caseTable[i] = '0;  // Kind 0 marks an unused entry
        end
        $readmemh("verif/programCases.txt", caseTable);
        for (int i = 0; i < caseWords; i++) begin
            {kind, addr, value} = caseTable[i];
            if (kind == 4'h1) begin
                mem[addr] = value[7:0];  // Little-endian instruction
                mem[cpuPkg::byteT'(addr + 1)] = value[15:8];
            end else if (kind == 4'h2) begin
                mem[addr] = value[7:0];
            end else if (kind == 4'h3) begin
                expAddr.push_back(addr);
                expData.push_back(value[7:0]);
            end
        end
    endtask

    task automatic waitForWrite();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles > writeTimeout) begin
                failRun("timed out waiting for the next memory write");
            end
        end while (memReq.write !== 1'b1);
    endtask

    initial begin
        int             cycles;
        cpuPkg::memReqT expReq;
        loadCases();
        if (expAddr.size() == 0) begin
            failRun("the case file holds no expected writes");
        end

        cycles = 0;
        while (rstN !== 1'b1) begin
            @(negedge clock);
            cycles++;
            if (cycles > resetTimeout) begin
                failRun("timed out waiting for reset release");
            end
        end

        expReq      = '0;
        expReq.read = 1'b1;
        checkRequest("memReq", memReq, expReq);
        @(negedge clock);
        expReq.addr = 8'h01;
        checkRequest("memReq", memReq, expReq);

        while (expAddr.size() > 0) begin
            waitForWrite();
            checkByte("memReq.addr", memReq.addr, expAddr.pop_front());
            checkByte("memReq.wrData", memReq.wrData, expData.pop_front());
        end

        // Program parks in a BRA loop
        for (int i = 0; i < quietCycles; i++) begin
            @(negedge clock);
            if (memReq.write === 1'b1) begin
                failRun($sformatf("unexpected write to address %h after the last store",
                                  memReq.addr));
            end
        end
        $display("No errors");
        $finish;
    end

endmodule

/* project.f */
source/cpuPkg.sv
source/registerFile.sv
source/addressRegisters.sv
source/alu.sv
source/dataPath.sv
source/controlSequencer.sv
source/cpuCore.sv
verif/tbClock.sv
verif/cpuCore_props.sv
verif/cpuCoreTb.sv

/* Makefile */
# Verilator build and run of the CPU core testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = cpuCoreTb
FILELIST  = project.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx 'No errors' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/programCases.txt */
// Word layout is kind_address_value
// Kind 1 places an instruction word, kind 2 a data byte, kind 3 is the next expected write
1_00_1411 1_02_1522 1_04_1633 1_06_1744  // LD immediates into R1 to R4
1_08_2080 1_0A_2181 1_0C_2282 1_0E_2383  // Store them
1_10_10F0 1_12_2084 2_F0_005C            // LD direct copies a preset byte
1_14_3540 1_16_2185                      // MOV R2 from R1
1_18_3270 1_1A_3620 1_1C_2286            // MOV into AR and back out
1_1E_143C 1_20_15A5 1_22_4645 1_24_2287  // AND
1_26_5745 1_28_2388                      // OR
1_2A_140F 1_2C_15F0 1_2E_4645            // Zero result
1_30_F036 1_32_2089 1_34_0038 1_36_218A  // BNE falls through, BRA skips a store
1_38_5645 1_3A_F040 1_3C_208B 1_3E_218C  // Nonzero result so BNE is taken
1_40_228D 1_42_0042                      // Last store then BRA to itself

3_80_0011 3_81_0022 3_82_0033 3_83_0044
3_84_005C 3_85_005C 3_86_0044
3_87_0024 3_88_00BD
3_89_000F 3_8D_00FF
